// File: audio_controller.f
src/audio_pkg.sv
src/clock_edge.sv
src/sample_fifo.sv
src/audio_in_deserializer.sv
src/audio_out_serializer.sv
src/audio_controller.sv
testbench/tb_audio_controller.sv

// File: Bender.yml
package:
  name: audio_controller

sources:
  - src/audio_pkg.sv
  - src/clock_edge.sv
  - src/sample_fifo.sv
  - src/audio_in_deserializer.sv
  - src/audio_out_serializer.sv
  - src/audio_controller.sv
  - target: test
    files:
      - testbench/tb_audio_controller.sv

// File: testbench/tb_audio_controller.sv
// Testbench for audio_controller with a codec model, random data and reference queues
`timescale 1ns/1ns
`default_nettype none

module tb_audio_controller;

	import audio_pkg::*;

	localparam int FRAME_CYCLES = 512;
	localparam int TEST_FRAMES  = 220;
	localparam int WATCHDOG_CYCLES = TEST_FRAMES * FRAME_CYCLES * 2;

	// Registered flags let two transfers through after the threshold is crossed
	localparam int GATED_COUNT = FIFO_DEPTH - FIFO_THRESHOLD + 2;

	logic           CLOCK_50;
	logic           reset;
	logic           clear_audio_in_memory;
	logic           read_audio_in;
	stereo_sample_t audio_in;
	logic           audio_in_available;
	logic           clear_audio_out_memory;
	logic           write_audio_out;
	stereo_sample_t audio_out;
	logic           audio_out_allowed;
	logic           AUD_ADCDAT;
	logic           AUD_BCLK;
	logic           AUD_ADCLRCK;
	logic           AUD_DACLRCK;
	logic           AUD_DACDAT;

	// Reference queues and model state
	stereo_sample_t adc_q[$];
	stereo_sample_t dac_q[$];
	logic [31:0]    rand_state;
	logic [31:0]    adc_left;
	logic [31:0]    adc_right;
	logic [63:0]    dac_word;
	int             phase;
	int             bit_idx;
	int             frames_started;
	int             adc_drops;
	int             dac_checked;
	int             reads_done;
	int             read_mode;
	bit             codec_run;
	bit             dac_run;
	bit             dac_active;
	bit             dac_check_frame;
	bit             skip_frame;
	bit             thresh_en;

	audio_controller u_dut (
		.CLOCK_50               (CLOCK_50),
		.reset                  (reset),
		.clear_audio_in_memory  (clear_audio_in_memory),
		.read_audio_in          (read_audio_in),
		.audio_in               (audio_in),
		.audio_in_available     (audio_in_available),
		.clear_audio_out_memory (clear_audio_out_memory),
		.write_audio_out        (write_audio_out),
		.audio_out              (audio_out),
		.audio_out_allowed      (audio_out_allowed),
		.AUD_ADCDAT             (AUD_ADCDAT),
		.AUD_BCLK               (AUD_BCLK),
		.AUD_ADCLRCK            (AUD_ADCLRCK),
		.AUD_DACLRCK            (AUD_DACLRCK),
		.AUD_DACDAT             (AUD_DACDAT)
	);

	// LCG, numerical recipes constants
	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic wait_for_bit(input int idx);
		@(negedge CLOCK_50);
		while (bit_idx != idx)
			@(negedge CLOCK_50);
	endtask

	initial
	begin
		CLOCK_50 = 1'b0;
		forever
			#20 CLOCK_50 = ~CLOCK_50;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
		stop_with_error("timeout: the test did not complete within the expected time");
	end

	// Codec model, one bit period is 8 CLOCK_50 cycles
	always @(posedge CLOCK_50)
	begin
		if (codec_run)
		begin
			if (phase == 0)
			begin
				AUD_BCLK <= 1'b0;
				bit_idx = (bit_idx + 1) % 64;
				if (bit_idx == 0)
				begin
					// Frame 0 is lost because the sync flag sets on its own edge
					if (frames_started >= 2 && !skip_frame)
					begin
						if (adc_q.size() < FIFO_DEPTH)
							adc_q.push_back({adc_left, adc_right});
						else
							adc_drops++;
					end
					if (frames_started >= 1)
						skip_frame = 1'b0;
					frames_started++;
					adc_left  = next_rand();
					adc_right = next_rand();
					dac_check_frame = dac_active;
				end
				AUD_ADCLRCK <= (bit_idx < 32);
				AUD_ADCDAT  <= (bit_idx < 32) ? adc_left[31 - bit_idx] : adc_right[63 - bit_idx];
				AUD_DACLRCK <= dac_run ? (bit_idx < 32) : 1'b1;
				if (dac_run && bit_idx >= 32)
					dac_active = 1'b1;
			end
			else if (phase == 4)
				AUD_BCLK <= 1'b1;
			else if (phase == 6 && dac_check_frame)
			begin
				// Mid-high sample, well away from the DUT shift edge
				dac_word[63 - bit_idx] = AUD_DACDAT;
				if (bit_idx == 63)
				begin
					if (dac_q.size() > 0)
						check_value("AUD_DACDAT frame", dac_word, dac_q.pop_front());
					else
						check_value("AUD_DACDAT frame", dac_word, 64'h0);
					dac_checked++;
				end
			end
			phase = (phase + 1) % 8;
		end
	end

	// Reader drives on the rising edge, commits at the falling edge
	initial
	begin
		read_audio_in = 1'b0;
		forever
		begin
			@(posedge CLOCK_50);
			if (read_mode == 2)
				read_audio_in <= 1'b1;
			else if (read_mode == 1)
				read_audio_in <= next_rand() >> 31;
			else
				read_audio_in <= 1'b0;
			@(negedge CLOCK_50);
			if (read_audio_in && audio_in_available)
			begin
				if (adc_q.size() == 0)
					stop_with_error("read accepted while the reference queue was empty");
				check_value("audio_in", audio_in, adc_q.pop_front());
				reads_done++;
			end
			if (thresh_en && adc_q.size() < 60)
				check_value("audio_in_available", audio_in_available, 1'b0);
			if (thresh_en && adc_q.size() >= 68)
				check_value("audio_in_available", audio_in_available, 1'b1);
		end
	end

	initial
	begin
		int accepted;

		rand_state = 32'd75;
		reset = 1'b1;
		clear_audio_in_memory  = 1'b0;
		clear_audio_out_memory = 1'b0;
		write_audio_out = 1'b0;
		audio_out  = '0;
		AUD_ADCDAT  = 1'b0;
		AUD_BCLK    = 1'b1;
		AUD_ADCLRCK = 1'b0;
		AUD_DACLRCK = 1'b1;
		phase = 0;
		bit_idx = 63;
		accepted = 0;

		repeat (15) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		check_value("audio_in_available", audio_in_available, 1'b0);
		check_value("audio_out_allowed", audio_out_allowed, 1'b0);
		check_value("AUD_DACDAT", AUD_DACDAT, 1'b0);
		codec_run = 1'b1;
		@(posedge CLOCK_50);
		reset <= 1'b0;
		thresh_en = 1'b1;
		repeat (4) @(negedge CLOCK_50);
		check_value("audio_out_allowed", audio_out_allowed, 1'b1);
		check_value("AUD_DACDAT", AUD_DACDAT, 1'b0);

		// Writes past the threshold are refused by the gating
		for (int i = 0; i < 80; i++)
		begin
			@(posedge CLOCK_50);
			write_audio_out <= 1'b1;
			audio_out <= {next_rand(), next_rand()};
			@(negedge CLOCK_50);
			if (write_audio_out && audio_out_allowed)
			begin
				dac_q.push_back(audio_out);
				accepted++;
			end
		end
		@(posedge CLOCK_50);
		write_audio_out <= 1'b0;
		check_value("accepted writes", accepted, GATED_COUNT);

		// Playback with random reads on the capture side
		@(negedge CLOCK_50);
		dac_run = 1'b1;
		read_mode = 1;
		while (dac_checked < accepted + 2)
			@(negedge CLOCK_50);

		// Overflow with no reads
		read_mode = 0;
		while (adc_drops < 3)
			@(negedge CLOCK_50);
		check_value("audio_in_available", audio_in_available, 1'b1);

		// Drain mid frame so no push is pending
		wait_for_bit(16);
		reads_done = 0;
		read_mode = 2;
		while (audio_in_available)
			@(negedge CLOCK_50);
		read_mode = 0;
		check_value("audio_in reads from full", reads_done, GATED_COUNT);

		wait_for_bit(16);
		thresh_en = 1'b0;
		@(posedge CLOCK_50);
		clear_audio_in_memory <= 1'b1;
		adc_q.delete();
		skip_frame = 1'b1;
		@(posedge CLOCK_50);
		clear_audio_in_memory <= 1'b0;
		repeat (3) @(negedge CLOCK_50);
		check_value("audio_in_available", audio_in_available, 1'b0);
		thresh_en = 1'b1;

		// Capture restarts cleanly after the clear
		reads_done = 0;
		read_mode = 1;
		while (reads_done < 8)
			@(negedge CLOCK_50);
		read_mode = 0;

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/audio_controller.sv
// Codec interface top: edge detection, channel sync, sample FIFOs and user status flags
`timescale 1ns/1ns
`default_nettype none

module audio_controller (
	input  logic                      CLOCK_50,
	input  logic                      reset,
	input  logic                      clear_audio_in_memory,
	input  logic                      read_audio_in,
	output audio_pkg::stereo_sample_t audio_in,
	output logic                      audio_in_available,
	input  logic                      clear_audio_out_memory,
	input  logic                      write_audio_out,
	input  audio_pkg::stereo_sample_t audio_out,
	output logic                      audio_out_allowed,
	input  logic                      AUD_ADCDAT,
	input  logic                      AUD_BCLK,
	input  logic                      AUD_ADCLRCK,
	input  logic                      AUD_DACLRCK,
	output logic                      AUD_DACDAT
);

	import audio_pkg::*;

	// Codec clock edges, all on CLOCK_50
	logic bclk_rise;
	logic bclk_fall;
	logic adc_lr_rise;
	logic adc_lr_fall;
	logic dac_lr_rise;
	logic dac_lr_fall;

	// Frame alignment seen once per clock
	logic adc_synced;
	logic dac_synced;

	// Per-direction clears
	logic in_clear;
	logic out_clear;

	logic           adc_push;
	stereo_sample_t adc_sample;
	logic           in_pop;
	logic [FIFO_COUNT_WIDTH-1:0] in_fill;

	logic           out_push;
	logic           dac_pop;
	stereo_sample_t dac_head;
	logic [FIFO_COUNT_WIDTH-1:0] out_free;
	logic           out_empty;

	assign in_clear  = reset | clear_audio_in_memory;
	assign out_clear = reset | clear_audio_out_memory;

	clock_edge u_bclk_edge (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.test_clk     (AUD_BCLK),
		.rising_edge  (bclk_rise),
		.falling_edge (bclk_fall)
	);

	clock_edge u_adc_lr_edge (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.test_clk     (AUD_ADCLRCK),
		.rising_edge  (adc_lr_rise),
		.falling_edge (adc_lr_fall)
	);

	clock_edge u_dac_lr_edge (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.test_clk     (AUD_DACLRCK),
		.rising_edge  (dac_lr_rise),
		.falling_edge (dac_lr_fall)
	);

	// ADC locks on a left start, DAC on a right start
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			adc_synced <= 1'b0;
			dac_synced <= 1'b0;
		end
		else
		begin
			if (adc_lr_rise)
				adc_synced <= 1'b1;
			if (dac_lr_fall)
				dac_synced <= 1'b1;
		end
	end

	audio_in_deserializer u_deserializer (
		.CLOCK_50       (CLOCK_50),
		.clear          (in_clear),
		.bclk_rise      (bclk_rise),
		.lr_rise        (adc_lr_rise),
		.lr_fall        (adc_lr_fall),
		.channel_synced (adc_synced),
		.adcdat         (AUD_ADCDAT),
		.push           (adc_push),
		.sample         (adc_sample)
	);

	// User reads count only while enough is waiting
	assign in_pop = read_audio_in & audio_in_available;

	sample_fifo u_in_fifo (
		.CLOCK_50   (CLOCK_50),
		.clear      (in_clear),
		.push       (adc_push),
		.push_data  (adc_sample),
		.pop        (in_pop),
		.head_data  (audio_in),
		.fill_count (in_fill),
		.free_space (),
		.empty      ()
	);

	// User writes count only while enough room is free
	assign out_push = write_audio_out & audio_out_allowed;

	sample_fifo u_out_fifo (
		.CLOCK_50   (CLOCK_50),
		.clear      (out_clear),
		.push       (out_push),
		.push_data  (audio_out),
		.pop        (dac_pop),
		.head_data  (dac_head),
		.fill_count (),
		.free_space (out_free),
		.empty      (out_empty)
	);

	audio_out_serializer u_serializer (
		.CLOCK_50       (CLOCK_50),
		.clear          (out_clear),
		.bclk_fall      (bclk_fall),
		.lr_rise        (dac_lr_rise),
		.lr_fall        (dac_lr_fall),
		.channel_synced (dac_synced),
		.fifo_empty     (out_empty),
		.head_data      (dac_head),
		.pop            (dac_pop),
		.dacdat         (AUD_DACDAT)
	);

	// Status levels, one cycle behind the counts
	always_ff @(posedge CLOCK_50)
	begin
		if (in_clear)
			audio_in_available <= 1'b0;
		else
			audio_in_available <= (in_fill >= FIFO_THRESHOLD);
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (out_clear)
			audio_out_allowed <= 1'b0;
		else
			audio_out_allowed <= (out_free >= FIFO_THRESHOLD);
	end

endmodule

`default_nettype wire

// File: src/audio_out_serializer.sv
// Pops stereo pairs from the output FIFO and shifts them MSB first onto the DAC line
`timescale 1ns/1ns
`default_nettype none

module audio_out_serializer (
	input  logic                      CLOCK_50,
	input  logic                      clear,
	input  logic                      bclk_fall,
	input  logic                      lr_rise,
	input  logic                      lr_fall,
	input  logic                      channel_synced,
	input  logic                      fifo_empty,
	input  audio_pkg::stereo_sample_t head_data,
	output logic                      pop,
	output logic                      dacdat
);

	import audio_pkg::*;

	// Word on the line, and the right word parked for the second half
	logic [AUDIO_DATA_WIDTH-1:0] shift_reg;
	logic [AUDIO_DATA_WIDTH-1:0] right_hold;

	logic frame_start;

	// Frame starts on LR rise once the DAC clock is locked
	assign frame_start = channel_synced && lr_rise;

	// Take the head only when there is one
	assign pop = frame_start && !fifo_empty;

	always_ff @(posedge CLOCK_50)
	begin
		if (clear)
		begin
			shift_reg  <= '0;
			right_hold <= '0;
		end
		else if (frame_start)
		begin
			// Silent frame on underrun, timing never slips
			if (fifo_empty)
			begin
				shift_reg  <= '0;
				right_hold <= '0;
			end
			else
			begin
				shift_reg  <= head_data.left;
				right_hold <= head_data.right;
			end
		end
		else if (channel_synced && lr_fall)
			shift_reg <= right_hold;
		else if (bclk_fall)
			// Zero fill leaves the line low after the 32nd bit
			shift_reg <= {shift_reg[AUDIO_DATA_WIDTH-2:0], 1'b0};
	end

	// MSB on the pin as soon as a word loads
	assign dacdat = shift_reg[AUDIO_DATA_WIDTH-1];

	a_no_pop_when_empty : assert property (@(posedge CLOCK_50) disable iff (clear)
		!(pop && fifo_empty));

endmodule

`default_nettype wire

// File: src/audio_in_deserializer.sv
// Collects left-justified ADC bits into stereo pairs and pushes each pair to the input FIFO
`timescale 1ns/1ns
`default_nettype none

module audio_in_deserializer (
	input  logic                      CLOCK_50,
	input  logic                      clear,
	input  logic                      bclk_rise,
	input  logic                      lr_rise,
	input  logic                      lr_fall,
	input  logic                      channel_synced,
	input  logic                      adcdat,
	output logic                      push,
	output audio_pkg::stereo_sample_t sample
);

	import audio_pkg::*;

	// Shift registers hold payload only
	logic [AUDIO_DATA_WIDTH-1:0] left_shift;
	logic [AUDIO_DATA_WIDTH-1:0] right_shift;

	logic [BIT_COUNT_WIDTH-1:0] bit_count;
	// Word still taking bits
	logic                       active;
	// Current word is the right channel
	logic                       in_right;
	// A full left word waits for its right partner
	logic                       have_left;

	always_ff @(posedge CLOCK_50)
	begin
		if (bclk_rise && active)
		begin
			// MSB first, new bit enters at the bottom
			if (in_right)
				right_shift <= {right_shift[AUDIO_DATA_WIDTH-2:0], adcdat};
			else
				left_shift <= {left_shift[AUDIO_DATA_WIDTH-2:0], adcdat};
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (clear)
		begin
			bit_count <= '0;
			active    <= 1'b0;
			in_right  <= 1'b0;
			have_left <= 1'b0;
			push      <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			// LR high means left in this format
			if (channel_synced && (lr_rise || lr_fall))
			begin
				bit_count <= BIT_COUNTER_INIT;
				active    <= 1'b1;
				in_right  <= lr_fall;
			end
			else if (bclk_rise && active)
			begin
				if (bit_count == '0)
				begin
					// 32nd bit just taken, extra bits ignored
					active <= 1'b0;
					if (!in_right)
						have_left <= 1'b1;
					else if (have_left)
					begin
						push      <= 1'b1;
						have_left <= 1'b0;
					end
				end
				else
					bit_count <= bit_count - 1'b1;
			end
		end
	end

	// Pair read straight from the shift registers during push
	assign sample.left  = left_shift;
	assign sample.right = right_shift;

endmodule

`default_nettype wire

// File: src/sample_fifo.sv
// Show-ahead stereo sample FIFO with fill and free counts, one per audio direction
`timescale 1ns/1ns
`default_nettype none

module sample_fifo (
	input  logic                                   CLOCK_50,
	input  logic                                   clear,
	input  logic                                   push,
	input  audio_pkg::stereo_sample_t              push_data,
	input  logic                                   pop,
	output audio_pkg::stereo_sample_t              head_data,
	output logic [audio_pkg::FIFO_COUNT_WIDTH-1:0] fill_count,
	output logic [audio_pkg::FIFO_COUNT_WIDTH-1:0] free_space,
	output logic                                   empty
);

	import audio_pkg::*;

	localparam logic [FIFO_COUNT_WIDTH-1:0] FULL_COUNT = FIFO_COUNT_WIDTH'(FIFO_DEPTH);

	// Sample storage, no reset
	stereo_sample_t mem [FIFO_DEPTH];

	logic [FIFO_ADDR_WIDTH-1:0]  wr_ptr;
	logic [FIFO_ADDR_WIDTH-1:0]  rd_ptr;
	logic [FIFO_COUNT_WIDTH-1:0] count;
	logic                        do_push;
	logic                        do_pop;

	// Drop push when full, ignore pop when empty
	assign do_push = push && (count != FULL_COUNT);
	assign do_pop  = pop && (count != '0);

	always_ff @(posedge CLOCK_50)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	// Pointers wrap naturally at 128
	always_ff @(posedge CLOCK_50)
	begin
		if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Head word visible without a pop
	assign head_data  = mem[rd_ptr];
	assign fill_count = count;
	assign free_space = FULL_COUNT - count;
	assign empty      = (count == '0);

	a_counts_sum_to_depth : assert property (@(posedge CLOCK_50) disable iff (clear)
		(int'(fill_count) + int'(free_space)) == FIFO_DEPTH);

	a_count_within_depth : assert property (@(posedge CLOCK_50) disable iff (clear)
		fill_count <= FULL_COUNT);

endmodule

`default_nettype wire

// File: src/clock_edge.sv
// Samples one codec clock on CLOCK_50 and emits single-cycle rise and fall pulses
`timescale 1ns/1ns
`default_nettype none

module clock_edge (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic test_clk,
	output logic rising_edge,
	output logic falling_edge
);

	// Two-flop synchronizer, then the previous synchronized level
	logic sync_0;
	logic sync_1;
	logic prev_level;

	// Sync chain tracks the pin even in reset
	// so no false edge shows up on reset release
	always_ff @(posedge CLOCK_50)
	begin
		sync_0     <= test_clk;
		sync_1     <= sync_0;
		prev_level <= sync_1;
	end

	// Registered pulses, low through reset
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			rising_edge  <= 1'b0;
			falling_edge <= 1'b0;
		end
		else
		begin
			rising_edge  <= sync_1 & ~prev_level;
			falling_edge <= ~sync_1 & prev_level;
		end
	end

	// Rise and fall of one clock can never coincide
	a_one_edge_at_a_time : assert property (@(posedge CLOCK_50) disable iff (reset)
		!(rising_edge && falling_edge));

endmodule

`default_nettype wire

// File: src/audio_pkg.sv
// Shared widths, FIFO sizing and the stereo sample type, imported by every audio RTL block
`default_nettype none

package audio_pkg;

	// Bits per channel word on the serial lines
	localparam int AUDIO_DATA_WIDTH = 32;

	// Serial bit counters count down from width minus one
	localparam int BIT_COUNT_WIDTH = 5;
	localparam logic [BIT_COUNT_WIDTH-1:0] BIT_COUNTER_INIT = 5'd31;

	// Entries per direction FIFO
	localparam int FIFO_DEPTH = 128;
	localparam int FIFO_ADDR_WIDTH = 7;

	// Counts span 0 to 128 inclusive, hence one extra bit over the address
	localparam int FIFO_COUNT_WIDTH = 8;

	// Level at which a status flag reports enough samples or space
	localparam logic [FIFO_COUNT_WIDTH-1:0] FIFO_THRESHOLD = 8'd64;

	// One stereo pair, left word in the upper half
	typedef struct packed {
		logic [AUDIO_DATA_WIDTH-1:0] left;
		logic [AUDIO_DATA_WIDTH-1:0] right;
	} stereo_sample_t;

endpackage

`default_nettype wire
